/* source/noc_pkg.sv */
// mesh noc shared definitions
`default_nettype none

package noc_pkg;

  // field widths sized for meshes up to 4x4
  localparam int COORD_W = 2;
  localparam int DATA_W  = 8;

  // switch ports
  localparam int PORT_N = 5;

  localparam int PORT_LOCAL = 0;  // resource port
  localparam int PORT_LEFT  = 1;
  localparam int PORT_UP    = 2;
  localparam int PORT_RIGHT = 3;
  localparam int PORT_DOWN  = 4;

  // single flit packet
  typedef struct packed {
    logic [COORD_W-1:0] dst_x;  // destination column
    logic [COORD_W-1:0] dst_y;  // destination row
    logic [DATA_W-1:0]  data;
  } pckt_t;

endpackage

`default_nettype wire

/* source/noc_in_fifo.sv */
// switch input buffer
`timescale 1ns/1ns
`default_nettype none

module noc_in_fifo #(
  parameter int FIFO_DEPTH_W = 3
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           wren_i,
  input  noc_pkg::pckt_t pckt_i,
  input  logic           pop_i,
  output noc_pkg::pckt_t head_o,
  output logic           empty_o,
  output logic           full_o,
  output logic           ovrflw_o
);

  localparam logic [FIFO_DEPTH_W:0] DEPTH  = {1'b1, {FIFO_DEPTH_W{1'b0}}};
  localparam logic [FIFO_DEPTH_W:0] ALMOST = DEPTH - 1'b1;

  noc_pkg::pckt_t          mem_q [DEPTH];
  logic [FIFO_DEPTH_W-1:0] wr_ptr_q;
  logic [FIFO_DEPTH_W-1:0] rd_ptr_q;
  logic [FIFO_DEPTH_W:0]   cnt_q;
  logic [FIFO_DEPTH_W:0]   cnt_nxt;
  logic                    push;
  logic                    pull;
  logic                    drop;

  assign drop    = wren_i && (cnt_q == DEPTH);  // packet lost when truly full
  assign push    = wren_i && !drop;
  assign pull    = pop_i && !empty_o;
  assign empty_o = (cnt_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

  always_comb
  begin
    cnt_nxt = cnt_q;
    if (push && !pull)
      cnt_nxt = cnt_q + 1'b1;
    else if (pull && !push)
      cnt_nxt = cnt_q - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_o   <= 1'b0;
      ovrflw_o <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pull)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q  <= cnt_nxt;
      full_o <= (cnt_nxt >= ALMOST);  // one slot kept for the in-flight write
      if (drop)
        ovrflw_o <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= pckt_i;
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= DEPTH);

endmodule

`default_nettype wire

/* source/rr_arbiter.sv */
// round robin output arbiter
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [noc_pkg::PORT_N-1:0] req_i,
  input  logic                       advance_i,
  output logic [noc_pkg::PORT_N-1:0] gnt_o
);

  localparam int PTR_W = $clog2(noc_pkg::PORT_N);

  logic [PTR_W-1:0] last_q;   // previous winner
  logic [PTR_W-1:0] win_idx;

  // walk from farthest to nearest so the first requester after last_q wins
  always_comb
  begin
    int cand;
    gnt_o   = '0;
    win_idx = last_q;
    for (int i = noc_pkg::PORT_N; i >= 1; i--)
    begin
      cand = (int'(last_q) + i) % noc_pkg::PORT_N;
      if (req_i[cand])
      begin
        gnt_o       = '0;
        gnt_o[cand] = 1'b1;
        win_idx     = PTR_W'(cand);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      last_q <= PTR_W'(noc_pkg::PORT_N - 1);  // local port first
    else if (advance_i && |req_i)
      last_q <= win_idx;
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

endmodule

`default_nettype wire

/* source/xy_switch.sv */
// five port xy mesh switch
`timescale 1ns/1ns
`default_nettype none

module xy_switch #(
  parameter int X_CORD       = 0,
  parameter int Y_CORD       = 0,
  parameter int FIFO_DEPTH_W = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // input channels
  input  logic           [noc_pkg::PORT_N-1:0] wren_i,
  input  noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] pckt_i,
  output logic           [noc_pkg::PORT_N-1:0] full_o,
  output logic                                 ovrflw_o,
  // output channels
  input  logic           [noc_pkg::PORT_N-1:0] nxt_full_i,
  output logic           [noc_pkg::PORT_N-1:0] wren_o,
  output noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] pckt_o
);

  localparam int SEL_W = $clog2(noc_pkg::PORT_N);

  noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] head;
  logic           [noc_pkg::PORT_N-1:0] empty;
  logic           [noc_pkg::PORT_N-1:0] ovrflw;
  logic           [noc_pkg::PORT_N-1:0] pop;
  logic           [noc_pkg::PORT_N-1:0] fire;      // per output
  logic           [SEL_W-1:0]           route [noc_pkg::PORT_N];
  logic           [noc_pkg::PORT_N-1:0] req   [noc_pkg::PORT_N];  // [out][in]
  logic           [noc_pkg::PORT_N-1:0] gnt   [noc_pkg::PORT_N];  // [out][in]
  logic           [noc_pkg::PORT_N-1:0] take  [noc_pkg::PORT_N];  // [in][out]
  noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] win_pckt;

  // x first, then y
  function automatic logic [SEL_W-1:0] route_of(input noc_pkg::pckt_t p);
    if (int'(p.dst_x) < X_CORD)
      return SEL_W'(noc_pkg::PORT_LEFT);
    else if (int'(p.dst_x) > X_CORD)
      return SEL_W'(noc_pkg::PORT_RIGHT);
    else if (int'(p.dst_y) < Y_CORD)
      return SEL_W'(noc_pkg::PORT_UP);
    else if (int'(p.dst_y) > Y_CORD)
      return SEL_W'(noc_pkg::PORT_DOWN);
    else
      return SEL_W'(noc_pkg::PORT_LOCAL);
  endfunction

  for (genvar i = 0; i < noc_pkg::PORT_N; i++)
  begin : g_in
    noc_in_fifo #(
      .FIFO_DEPTH_W(FIFO_DEPTH_W)
    ) u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wren_i   (wren_i[i]),
      .pckt_i   (pckt_i[i]),
      .pop_i    (pop[i]),
      .head_o   (head[i]),
      .empty_o  (empty[i]),
      .full_o   (full_o[i]),
      .ovrflw_o (ovrflw[i])
    );

    assign route[i] = route_of(head[i]);

    // xy routing never lets two outputs claim one head
    a_single_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(take[i]));
  end

  always_comb
  begin
    for (int o = 0; o < noc_pkg::PORT_N; o++)
      for (int i = 0; i < noc_pkg::PORT_N; i++)
        req[o][i] = !empty[i] && (route[i] == SEL_W'(o));
  end

  for (genvar o = 0; o < noc_pkg::PORT_N; o++)
  begin : g_out
    rr_arbiter u_arb (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (req[o]),
      .advance_i (!nxt_full_i[o]),  // hold priority while stalled
      .gnt_o     (gnt[o])
    );
  end

  always_comb
  begin
    for (int o = 0; o < noc_pkg::PORT_N; o++)
    begin
      fire[o]     = !nxt_full_i[o] && |gnt[o];
      win_pckt[o] = '0;
      for (int i = 0; i < noc_pkg::PORT_N; i++)
      begin
        take[i][o] = gnt[o][i] && !nxt_full_i[o];
        if (gnt[o][i])
          win_pckt[o] = head[i];
      end
    end
    for (int i = 0; i < noc_pkg::PORT_N; i++)
      pop[i] = |take[i];
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      wren_o <= '0;
    else
      wren_o <= fire;  // one cycle strobe per packet
  end

  always_ff @(posedge clk_i)
  begin
    for (int o = 0; o < noc_pkg::PORT_N; o++)
      if (fire[o])
        pckt_o[o] <= win_pckt[o];
  end

  assign ovrflw_o = ovrflw[noc_pkg::PORT_LOCAL];

  // neighbours obey full, so only the client side may overflow
  a_no_link_ovrflw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ovrflw[noc_pkg::PORT_N-1:1] == '0);

endmodule

`default_nettype wire

/* source/mesh_xy_noc.sv */
// xy routed mesh network
`timescale 1ns/1ns
`default_nettype none

module mesh_xy_noc #(
  parameter int ROW_N        = 3,
  parameter int COL_M        = 3,
  parameter int FIFO_DEPTH_W = 3
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // client to network
  input  noc_pkg::pckt_t [ROW_N*COL_M-1:0] rsc_pckt_i,
  input  logic           [ROW_N*COL_M-1:0] rsc_wren_i,
  output logic           [ROW_N*COL_M-1:0] noc_full_o,
  output logic           [ROW_N*COL_M-1:0] noc_ovrflw_o,
  // network to client
  output noc_pkg::pckt_t [ROW_N*COL_M-1:0] noc_pckt_o,
  output logic           [ROW_N*COL_M-1:0] noc_wren_o,
  input  logic           [ROW_N*COL_M-1:0] rsc_full_i
);

  localparam int NODE_N = ROW_N * COL_M;

  // switch outputs indexed by node
  logic           [noc_pkg::PORT_N-1:0] sw_wren [NODE_N];
  noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] sw_pckt [NODE_N];
  logic           [noc_pkg::PORT_N-1:0] sw_full [NODE_N];

  for (genvar r = 0; r < ROW_N; r++)
  begin : g_row
    for (genvar c = 0; c < COL_M; c++)
    begin : g_col
      localparam int NODE = r * COL_M + c;

      logic           [noc_pkg::PORT_N-1:0] wren_in;
      noc_pkg::pckt_t [noc_pkg::PORT_N-1:0] pckt_in;
      logic           [noc_pkg::PORT_N-1:0] full_in;

      assign wren_in[noc_pkg::PORT_LOCAL] = rsc_wren_i[NODE];
      assign pckt_in[noc_pkg::PORT_LOCAL] = rsc_pckt_i[NODE];
      assign full_in[noc_pkg::PORT_LOCAL] = rsc_full_i[NODE];

      if (c > 0)
      begin : g_left
        assign wren_in[noc_pkg::PORT_LEFT] = sw_wren[NODE-1][noc_pkg::PORT_RIGHT];
        assign pckt_in[noc_pkg::PORT_LEFT] = sw_pckt[NODE-1][noc_pkg::PORT_RIGHT];
        assign full_in[noc_pkg::PORT_LEFT] = sw_full[NODE-1][noc_pkg::PORT_RIGHT];
      end
      else
      begin : g_left_edge
        assign wren_in[noc_pkg::PORT_LEFT] = 1'b0;
        assign pckt_in[noc_pkg::PORT_LEFT] = '0;
        assign full_in[noc_pkg::PORT_LEFT] = 1'b1;  // nothing leaves the mesh
      end

      if (r > 0)
      begin : g_up
        assign wren_in[noc_pkg::PORT_UP] = sw_wren[NODE-COL_M][noc_pkg::PORT_DOWN];
        assign pckt_in[noc_pkg::PORT_UP] = sw_pckt[NODE-COL_M][noc_pkg::PORT_DOWN];
        assign full_in[noc_pkg::PORT_UP] = sw_full[NODE-COL_M][noc_pkg::PORT_DOWN];
      end
      else
      begin : g_up_edge
        assign wren_in[noc_pkg::PORT_UP] = 1'b0;
        assign pckt_in[noc_pkg::PORT_UP] = '0;
        assign full_in[noc_pkg::PORT_UP] = 1'b1;
      end

      if (c < COL_M - 1)
      begin : g_right
        assign wren_in[noc_pkg::PORT_RIGHT] = sw_wren[NODE+1][noc_pkg::PORT_LEFT];
        assign pckt_in[noc_pkg::PORT_RIGHT] = sw_pckt[NODE+1][noc_pkg::PORT_LEFT];
        assign full_in[noc_pkg::PORT_RIGHT] = sw_full[NODE+1][noc_pkg::PORT_LEFT];
      end
      else
      begin : g_right_edge
        assign wren_in[noc_pkg::PORT_RIGHT] = 1'b0;
        assign pckt_in[noc_pkg::PORT_RIGHT] = '0;
        assign full_in[noc_pkg::PORT_RIGHT] = 1'b1;
      end

      if (r < ROW_N - 1)
      begin : g_down
        assign wren_in[noc_pkg::PORT_DOWN] = sw_wren[NODE+COL_M][noc_pkg::PORT_UP];
        assign pckt_in[noc_pkg::PORT_DOWN] = sw_pckt[NODE+COL_M][noc_pkg::PORT_UP];
        assign full_in[noc_pkg::PORT_DOWN] = sw_full[NODE+COL_M][noc_pkg::PORT_UP];
      end
      else
      begin : g_down_edge
        assign wren_in[noc_pkg::PORT_DOWN] = 1'b0;
        assign pckt_in[noc_pkg::PORT_DOWN] = '0;
        assign full_in[noc_pkg::PORT_DOWN] = 1'b1;
      end

      xy_switch #(
        .X_CORD       (c),
        .Y_CORD       (r),
        .FIFO_DEPTH_W (FIFO_DEPTH_W)
      ) u_sw (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wren_i     (wren_in),
        .pckt_i     (pckt_in),
        .full_o     (sw_full[NODE]),
        .ovrflw_o   (noc_ovrflw_o[NODE]),
        .nxt_full_i (full_in),
        .wren_o     (sw_wren[NODE]),
        .pckt_o     (sw_pckt[NODE])
      );

      // resource side
      assign noc_wren_o[NODE] = sw_wren[NODE][noc_pkg::PORT_LOCAL];
      assign noc_pckt_o[NODE] = sw_pckt[NODE][noc_pkg::PORT_LOCAL];
      assign noc_full_o[NODE] = sw_full[NODE][noc_pkg::PORT_LOCAL];
    end
  end

endmodule

`default_nettype wire

/* dv/mesh_xy_noc_tb.sv */
// mesh noc directed testbench
`timescale 1ns/1ns
`default_nettype none

module mesh_xy_noc_tb;

  localparam int ROW_N       = 3;
  localparam int COL_M       = 3;
  localparam int NODE_N      = ROW_N * COL_M;
  localparam int CLK_HALF    = 4;
  localparam int RAND_CYCLES = 200;
  localparam int TEST_CYCLES = NODE_N * NODE_N * 6 + 300 + RAND_CYCLES * 4;

  logic                        clk_i;
  logic                        rst_n_i;
  noc_pkg::pckt_t [NODE_N-1:0] rsc_pckt_i;
  logic           [NODE_N-1:0] rsc_wren_i;
  logic           [NODE_N-1:0] noc_full_o;
  logic           [NODE_N-1:0] noc_ovrflw_o;
  noc_pkg::pckt_t [NODE_N-1:0] noc_pckt_o;
  logic           [NODE_N-1:0] noc_wren_o;
  logic           [NODE_N-1:0] rsc_full_i;

  noc_pkg::pckt_t exp_q [NODE_N][$];  // per destination
  int             rx_cnt [NODE_N];
  logic [3:0]     seq_q [NODE_N];     // per source
  int             err_cnt;
  int             chk_cnt;
  int             test_cnt;
  integer         seed;

  mesh_xy_noc #(
    .ROW_N        (ROW_N),
    .COL_M        (COL_M),
    .FIFO_DEPTH_W (3)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rsc_pckt_i   (rsc_pckt_i),
    .rsc_wren_i   (rsc_wren_i),
    .noc_full_o   (noc_full_o),
    .noc_ovrflw_o (noc_ovrflw_o),
    .noc_pckt_o   (noc_pckt_o),
    .noc_wren_o   (noc_wren_o),
    .rsc_full_i   (rsc_full_i)
  );

  always #CLK_HALF clk_i = ~clk_i;

  initial
  begin
    #(TEST_CYCLES * 20 * 2 * CLK_HALF);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_pckt(input noc_pkg::pckt_t got, input noc_pkg::pckt_t exp,
                            input string msg);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("FAILED %0t: %s got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("FAILED %0t: %s got %b expected %b", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  // source node in the upper data nibble, sequence in the lower
  function automatic noc_pkg::pckt_t make_pckt(input int dst, input int src,
                                               input logic [3:0] seq);
    noc_pkg::pckt_t p;
    p.dst_x = noc_pkg::COORD_W'(dst % COL_M);
    p.dst_y = noc_pkg::COORD_W'(dst / COL_M);
    p.data  = {4'(src), seq};
    return p;
  endfunction

  function automatic int outstanding();
    int sum;
    sum = 0;
    for (int n = 0; n < NODE_N; n++)
      sum += exp_q[n].size();
    return sum;
  endfunction

  // ejection monitor keeps order per source and destination
  always @(negedge clk_i)
  begin : monitor
    int idx;
    for (int n = 0; n < NODE_N; n++)
    begin
      if (rst_n_i && noc_wren_o[n])
      begin
        idx = -1;
        for (int k = exp_q[n].size() - 1; k >= 0; k--)
          if (exp_q[n][k].data[7:4] == noc_pckt_o[n].data[7:4])
            idx = k;
        rx_cnt[n]++;
        if (idx < 0)
        begin
          $display("node %0d received packet %h that was never sent", n, noc_pckt_o[n]);
          err_cnt++;
        end
        else
        begin
          check_pckt(noc_pckt_o[n], exp_q[n][idx], $sformatf("ejected at node %0d", n));
          exp_q[n].delete(idx);
        end
      end
    end
  end

  task automatic apply_reset();
    rst_n_i    = 1'b0;
    rsc_wren_i = '0;
    rsc_pckt_i = '0;
    rsc_full_i = '0;
    repeat (2) tick();
    rst_n_i = 1'b1;
  endtask

  task automatic write_raw(input int src, input int dst, input logic stored);
    noc_pkg::pckt_t p;
    p = make_pckt(dst, src, seq_q[src]);
    seq_q[src]++;
    rsc_pckt_i[src] = p;
    rsc_wren_i[src] = 1'b1;
    if (stored)
      exp_q[dst].push_back(p);
    tick();
    rsc_wren_i[src] = 1'b0;
  endtask

  task automatic send(input int src, input int dst);
    while (noc_full_o[src])
      tick();
    write_raw(src, dst, 1'b1);
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (outstanding() != 0 && waited < limit)
    begin
      tick();
      waited++;
    end
    if (outstanding() != 0)
    begin
      $display("%0d packets never arrived", outstanding());
      err_cnt++;
    end
    repeat (10) tick();  // late duplicates
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    $display("test %s done, %0d errors", name, err_cnt - err_before);
  endtask

  task automatic test_reset_values();
    int e;
    e = err_cnt;
    for (int n = 0; n < NODE_N; n++)
    begin
      check_flag(noc_wren_o[n], 1'b0, $sformatf("noc_wren_o[%0d] after reset", n));
      check_flag(noc_full_o[n], 1'b0, $sformatf("noc_full_o[%0d] after reset", n));
      check_flag(noc_ovrflw_o[n], 1'b0, $sformatf("noc_ovrflw_o[%0d] after reset", n));
    end
    finish_test("reset_values", e);
  endtask

  task automatic test_all_pairs();
    int e;
    e = err_cnt;
    for (int s = 0; s < NODE_N; s++)
      for (int d = 0; d < NODE_N; d++)
        send(s, d);
    drain(500);
    finish_test("all_pairs", e);
  endtask

  task automatic test_stream();
    int e;
    e = err_cnt;
    for (int i = 0; i < 6; i++)
      send(0, 8);
    drain(200);
    finish_test("stream", e);
  endtask

  task automatic test_backpressure();
    int e;
    int sent;
    int rx_before;
    e         = err_cnt;
    sent      = 0;
    rx_before = rx_cnt[4];
    rsc_full_i[4] = 1'b1;
    while (!noc_full_o[3] && sent < 40)
    begin
      send(3, 4);
      sent++;
    end
    check_flag(noc_full_o[3], 1'b1, "node 3 full under back-pressure");
    repeat (20) tick();
    check_flag(rx_cnt[4] == rx_before, 1'b1, "no ejection at blocked node 4");
    rsc_full_i[4] = 1'b0;
    drain(300);
    check_flag(noc_ovrflw_o[3], 1'b0, "node 3 overflow after back-pressure");
    finish_test("backpressure", e);
  endtask

  task automatic test_overflow();
    int e;
    e = err_cnt;
    rsc_full_i[0] = 1'b1;
    while (!noc_full_o[0])
      send(0, 0);
    write_raw(0, 0, 1'b1);  // last free slot
    write_raw(0, 0, 1'b0);  // dropped
    check_flag(noc_ovrflw_o[0], 1'b1, "overflow after write into full fifo");
    rsc_full_i[0] = 1'b0;
    drain(200);
    check_flag(noc_ovrflw_o[0], 1'b1, "overflow sticky after drain");
    apply_reset();
    check_flag(noc_ovrflw_o[0], 1'b0, "overflow cleared by reset");
    finish_test("overflow", e);
  endtask

  task automatic test_random();
    int e;
    int dst;
    noc_pkg::pckt_t p;
    e = err_cnt;
    for (int cyc = 0; cyc < RAND_CYCLES; cyc++)
    begin
      for (int n = 0; n < NODE_N; n++)
      begin
        rsc_wren_i[n] = 1'b0;
        if (!noc_full_o[n] && ($random(seed) & 1))
        begin
          dst = ($random(seed) & 32'hff) % NODE_N;
          p   = make_pckt(dst, n, seq_q[n]);
          seq_q[n]++;
          rsc_pckt_i[n] = p;
          rsc_wren_i[n] = 1'b1;
          exp_q[dst].push_back(p);
        end
      end
      tick();
    end
    rsc_wren_i = '0;
    drain(1000);
    finish_test("random", e);
  endtask

  initial
  begin
    seed     = 14045;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    clk_i    = 1'b0;
    for (int n = 0; n < NODE_N; n++)
    begin
      seq_q[n]  = '0;
      rx_cnt[n] = 0;
    end
    apply_reset();
    test_reset_values();
    test_all_pairs();
    test_stream();
    test_backpressure();
    test_overflow();
    test_random();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* mesh_xy_noc.f */
source/noc_pkg.sv
source/noc_in_fifo.sv
source/rr_arbiter.sv
source/xy_switch.sv
source/mesh_xy_noc.sv
dv/mesh_xy_noc_tb.sv

/* Bender.yml */
package:
  name: mesh_xy_noc

sources:
  - source/noc_pkg.sv
  - source/noc_in_fifo.sv
  - source/rr_arbiter.sv
  - source/xy_switch.sv
  - source/mesh_xy_noc.sv
  - target: test
    files:
      - dv/mesh_xy_noc_tb.sv
